/* src/maxnet_cfg.svh */
`ifndef MAXNET_CFG_SVH
`define MAXNET_CFG_SVH

// Q16.16 fixed point for all lane values
`define MAXNET_FRAC_BITS 16

// lateral inhibition weight, 0.125 in Q16.16
`define MAXNET_EPSILON 32'h2000

`define MAXNET_MAX_ITER 200

`define MAXNET_ADDR_IN0    3'd0
`define MAXNET_ADDR_IN1    3'd1
`define MAXNET_ADDR_IN2    3'd2
`define MAXNET_ADDR_IN3    3'd3
`define MAXNET_ADDR_CTRL   3'd4
`define MAXNET_ADDR_STATUS 3'd5
`define MAXNET_ADDR_MAXVAL 3'd6
`define MAXNET_ADDR_INFO   3'd7

`endif

/* src/maxnetPkg.sv */
`default_nettype none

package maxnetPkg;

    typedef logic signed [31:0] fixVal;
    typedef logic [1:0] laneIdx;
    typedef logic [7:0] iterCount;
    typedef logic [2:0] regAddr;
    typedef logic [31:0] wbData;

    typedef enum logic [1:0] {idle, load, iterate, finish} netState;

    typedef struct packed {
        fixVal lane0;
        fixVal lane1;
        fixVal lane2;
        fixVal lane3;
    } laneSet;

    // host to slave half of a Wishbone classic cycle
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        regAddr adr;
        wbData dat;
    } wbReq;

    typedef struct packed {
        logic ack;
        wbData dat;
    } wbRsp;

    typedef struct packed {
        laneIdx winner;
        fixVal maxValue;
        iterCount iterations;
        logic noWinner;
    } runResult;

endpackage

`default_nettype wire

/* src/inhibitLane.sv */
`timescale 1ns/10ps
`default_nettype none

`include "maxnet_cfg.svh"

module inhibitLane
    import maxnetPkg::*;
(
    input  fixVal self,
    input  fixVal other0,
    input  fixVal other1,
    input  fixVal other2,
    output fixVal next
);

    localparam fixVal epsilon = `MAXNET_EPSILON;

    logic signed [63:0] sumWide;
    logic signed [63:0] product;
    logic signed [63:0] inhibit;
    logic signed [63:0] diff;

    // sign extend first so the three-way sum cannot wrap
    assign sumWide = 64'(other0) + 64'(other1) + 64'(other2);
    assign product = sumWide * 64'(epsilon);
    assign inhibit = product >>> `MAXNET_FRAC_BITS;
    assign diff = 64'(self) - inhibit;

    always_comb begin
        if (diff < 0) begin
            next = '0;
        end else if (diff > 64'sh7fff_ffff) begin
            // a large negative neighbour can push a positive lane past Q16.16 range
            next = 32'sh7fff_ffff;
        end else begin
            next = diff[31:0];
        end
    end

endmodule

`default_nettype wire

/* src/maxnetRegDecode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "maxnet_cfg.svh"

module maxnetRegDecode
    import maxnetPkg::*;
(
    input  wire logic clk,
    input  wire logic rstN,
    input  wbReq bus,
    output wbRsp busRsp,
    input  wire logic busy,
    input  wire logic done,
    input  wire logic limitHit,
    input  runResult result,
    output laneSet inputs,
    output logic startPulse
);

    logic ackQ;
    logic startQ;
    logic access;
    logic wrEn;
    wbData rdDataQ;
    wbData readMux;
    laneSet inRegs;

    // a new access is taken only while no ack is pending, so each stb
    // phase gives exactly one acknowledged transfer
    assign access = bus.cyc & bus.stb & ~ackQ;
    assign wrEn = access & bus.we;

    always_comb begin
        readMux = '0;
        case (bus.adr)
            `MAXNET_ADDR_IN0: readMux = inRegs.lane0;
            `MAXNET_ADDR_IN1: readMux = inRegs.lane1;
            `MAXNET_ADDR_IN2: readMux = inRegs.lane2;
            `MAXNET_ADDR_IN3: readMux = inRegs.lane3;
            `MAXNET_ADDR_STATUS: readMux = {28'd0, limitHit, result.noWinner, done, busy};
            `MAXNET_ADDR_MAXVAL: readMux = result.maxValue;
            `MAXNET_ADDR_INFO: readMux = {16'd0, result.iterations, 6'd0, result.winner};
            default: readMux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ackQ <= 1'b0;
            startQ <= 1'b0;
        end else begin
            ackQ <= access;
            // start is dropped while a run is active or already requested
            startQ <= wrEn && (bus.adr == `MAXNET_ADDR_CTRL) && bus.dat[0]
                      && !busy && !startQ;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !bus.we) begin
            rdDataQ <= readMux;
        end
        if (wrEn) begin
            case (bus.adr)
                `MAXNET_ADDR_IN0: inRegs.lane0 <= bus.dat;
                `MAXNET_ADDR_IN1: inRegs.lane1 <= bus.dat;
                `MAXNET_ADDR_IN2: inRegs.lane2 <= bus.dat;
                `MAXNET_ADDR_IN3: inRegs.lane3 <= bus.dat;
                default: ;
            endcase
        end
    end

    assign busRsp = '{ack: ackQ, dat: rdDataQ};
    assign inputs = inRegs;
    assign startPulse = startQ;

    // the slave never acknowledges on its own
    ackNeedsStb: assert property (
        @(posedge clk) disable iff (!rstN)
        busRsp.ack |-> $past(bus.cyc && bus.stb)
    ) else $error("ack raised without a preceding strobe");

endmodule

`default_nettype wire

/* src/maxnetIterate.sv */
`timescale 1ns/10ps
`default_nettype none

`include "maxnet_cfg.svh"

module maxnetIterate
    import maxnetPkg::*;
(
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic startPulse,
    input  laneSet inputs,
    output laneSet lanes,
    output logic busy,
    output logic runEnd,
    output iterCount iterations,
    output logic limitHit
);

    netState state;
    laneSet laneQ;
    laneSet laneNext;
    iterCount iterQ;
    logic limitQ;
    logic [2:0] liveCount;
    logic converged;
    logic atLimit;

    // every lane sees the other three as inhibitors
    inhibitLane lane0Inst (.self(laneQ.lane0), .other0(laneQ.lane1), .other1(laneQ.lane2),
                           .other2(laneQ.lane3), .next(laneNext.lane0));
    inhibitLane lane1Inst (.self(laneQ.lane1), .other0(laneQ.lane0), .other1(laneQ.lane2),
                           .other2(laneQ.lane3), .next(laneNext.lane1));
    inhibitLane lane2Inst (.self(laneQ.lane2), .other0(laneQ.lane0), .other1(laneQ.lane1),
                           .other2(laneQ.lane3), .next(laneNext.lane2));
    inhibitLane lane3Inst (.self(laneQ.lane3), .other0(laneQ.lane0), .other1(laneQ.lane1),
                           .other2(laneQ.lane2), .next(laneNext.lane3));

    assign liveCount = {2'd0, |laneNext.lane0} + {2'd0, |laneNext.lane1}
                     + {2'd0, |laneNext.lane2} + {2'd0, |laneNext.lane3};
    assign converged = (liveCount <= 3'd1);
    // this iteration brings the count up to the limit
    assign atLimit = (iterQ == 8'(`MAXNET_MAX_ITER - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
            laneQ <= '0;
            iterQ <= '0;
            limitQ <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (startPulse) begin
                        state <= load;
                    end
                end
                load: begin
                    laneQ <= inputs;
                    iterQ <= '0;
                    limitQ <= 1'b0;
                    state <= iterate;
                end
                iterate: begin
                    laneQ <= laneNext;
                    iterQ <= iterQ + 8'd1;
                    if (converged) begin
                        state <= finish;
                    end else if (atLimit) begin
                        limitQ <= 1'b1;
                        state <= finish;
                    end
                end
                finish: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    assign lanes = laneQ;
    assign busy = (state != idle);
    assign runEnd = (state == finish);
    assign iterations = iterQ;
    assign limitHit = limitQ;

    iterBounded: assert property (
        @(posedge clk) disable iff (!rstN)
        iterations <= 8'(`MAXNET_MAX_ITER)
    ) else $error("iteration count passed the limit");

    endInsideRun: assert property (
        @(posedge clk) disable iff (!rstN)
        runEnd |-> busy && $past(busy)
    ) else $error("runEnd outside a busy run");

endmodule

`default_nettype wire

/* src/winnerSelect.sv */
`timescale 1ns/10ps
`default_nettype none

`include "maxnet_cfg.svh"

module winnerSelect
    import maxnetPkg::*;
(
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic startPulse,
    input  laneSet inputs,
    input  laneSet lanes,
    input  wire logic runEnd,
    input  iterCount iterations,
    output runResult result,
    output logic done
);

    laneSet origQ;
    runResult resQ;
    logic doneQ;
    logic [3:0] liveBits;
    laneIdx winner;
    fixVal winnerOrig;

    assign liveBits = {|lanes.lane3, |lanes.lane2, |lanes.lane1, |lanes.lane0};

    // lowest index wins when several lanes survive
    always_comb begin
        winner = 2'd0;
        if (liveBits[0]) winner = 2'd0;
        else if (liveBits[1]) winner = 2'd1;
        else if (liveBits[2]) winner = 2'd2;
        else if (liveBits[3]) winner = 2'd3;
    end

    always_comb begin
        case (winner)
            2'd0: winnerOrig = origQ.lane0;
            2'd1: winnerOrig = origQ.lane1;
            2'd2: winnerOrig = origQ.lane2;
            default: winnerOrig = origQ.lane3;
        endcase
    end

    always_ff @(posedge clk) begin
        if (startPulse) begin
            origQ <= inputs;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resQ <= '0;
            doneQ <= 1'b0;
        end else if (startPulse) begin
            doneQ <= 1'b0;
        end else if (runEnd) begin
            resQ.winner <= winner;
            resQ.maxValue <= winnerOrig;
            resQ.iterations <= iterations;
            resQ.noWinner <= ~|liveBits;
            doneQ <= 1'b1;
        end
    end

    assign result = resQ;
    assign done = doneQ;

    singleSurvivor: assert property (
        @(posedge clk) disable iff (!rstN)
        (runEnd && iterations != 8'(`MAXNET_MAX_ITER)) |-> ($countones(liveBits) <= 1)
    ) else $error("run ended with several lanes alive below the limit");

endmodule

`default_nettype wire

/* src/maxnetTop.sv */
`timescale 1ns/10ps
`default_nettype none

module maxnetTop
    import maxnetPkg::*;
(
    input  wire logic clk,
    input  wire logic rstN,
    input  wbReq bus,
    output wbRsp busRsp,
    output logic irq
);

    logic busy;
    logic limitHit;
    logic startPulse;
    logic runEnd;
    laneSet inputs;
    laneSet lanes;
    iterCount iterations;
    runResult result;

    maxnetRegDecode maxnetRegDecode_inst (
        .clk(clk),
        .rstN(rstN),
        .bus(bus),
        .busRsp(busRsp),
        .busy(busy),
        .done(irq),
        .limitHit(limitHit),
        .result(result),
        .inputs(inputs),
        .startPulse(startPulse)
    );

    maxnetIterate maxnetIterate_inst (
        .clk(clk),
        .rstN(rstN),
        .startPulse(startPulse),
        .inputs(inputs),
        .lanes(lanes),
        .busy(busy),
        .runEnd(runEnd),
        .iterations(iterations),
        .limitHit(limitHit)
    );

    // done doubles as the interrupt line
    winnerSelect winnerSelect_inst (
        .clk(clk),
        .rstN(rstN),
        .startPulse(startPulse),
        .inputs(inputs),
        .lanes(lanes),
        .runEnd(runEnd),
        .iterations(iterations),
        .result(result),
        .done(irq)
    );

endmodule

`default_nettype wire

/* sim/maxnetTbTasks.svh */
`ifndef MAXNET_TB_TASKS_SVH
`define MAXNET_TB_TASKS_SVH

// one classic cycle, stb held until the registered ack comes back
task automatic busCycle(input logic we, input regAddr addr, input wbData wdat,
                        output wbData rdat);
    int waitCycles;
    rdat = '0;
    if (hung) return;
    @(negedge clk);
    bus = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: wdat};
    waitCycles = 0;
    do begin
        @(negedge clk);
        waitCycles++;
    end while (!busRsp.ack && waitCycles < 16);
    rdat = busRsp.dat;
    bus = '0;
    if (!busRsp.ack) begin
        $display("register %0d gave no ack within %0d cycles", addr, waitCycles);
        hung = 1'b1;
    end else begin
        checkEq("ack latency", 32'(waitCycles), 32'd1);
    end
endtask

// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
function automatic logic [31:0] randBits(input int count);
    logic [31:0] bits;
    logic fb;
    bits = '0;
    for (int i = 0; i < count; i++) begin
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        bits = {bits[30:0], fb};
    end
    return bits;
endfunction

// expected outcome of a run from the inhibition and stop rules
function automatic runResult modelRun(input fixVal start [4], output logic limit);
    fixVal cur [4];
    fixVal nxt [4];
    logic signed [63:0] acc;
    int live;
    runResult res;
    cur = start;
    res = '0;
    limit = 1'b0;
    do begin
        live = 0;
        for (int i = 0; i < 4; i++) begin
            acc = 64'sd0;
            for (int j = 0; j < 4; j++) begin
                if (j != i) acc = acc + 64'(cur[j]);
            end
            acc = (acc * $signed(64'(`MAXNET_EPSILON))) >>> `MAXNET_FRAC_BITS;
            acc = 64'(cur[i]) - acc;
            // values past the Q16.16 range saturate
            if (acc < 64'sd0) nxt[i] = '0;
            else if (acc > 64'sh7fff_ffff) nxt[i] = 32'sh7fff_ffff;
            else nxt[i] = acc[31:0];
            if (nxt[i] != '0) live++;
        end
        cur = nxt;
        res.iterations++;
        limit = (live > 1) && (res.iterations == 8'(`MAXNET_MAX_ITER));
    end while (live > 1 && !limit);
    for (int i = 3; i >= 0; i--) begin
        if (cur[i] != '0) res.winner = 2'(i);
    end
    res.noWinner = (live == 0);
    res.maxValue = start[res.winner];
    return res;
endfunction

`endif

/* sim/maxnetTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "maxnet_cfg.svh"

module maxnetTb
    import maxnetPkg::*;
();

    logic clk;
    logic rstN;
    wbReq bus;
    wbRsp busRsp;
    logic irq;

    logic [31:0] lfsr;
    logic [31:0] rnd;
    logic hung;
    int errorCount;
    int checkCount;
    int testCount;
    int failedTests;
    int mark;
    fixVal vals [4];
    wbData rd;
    wbData info;

    maxnetTop maxnetTop_inst (
        .clk(clk), .rstN(rstN), .bus(bus), .busRsp(busRsp), .irq(irq)
    );

    `include "maxnetTbTasks.svh"

    task automatic checkEq(input string name, input logic [31:0] got,
                           input logic [31:0] want);
        checkCount++;
        assert (got === want) else begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, want, got);
            errorCount++;
        end
    endtask

    task automatic waitIrq(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (irq !== level && !hung) begin
            @(negedge clk);
            cycles++;
            if (irq !== level && cycles >= limit) begin
                $display("irq did not go to %0b within %0d cycles", level, limit);
                hung = 1'b1;
            end
        end
    endtask

    // load vals, start a run and compare the result registers with the model
    task automatic runCase(input logic extraStart, output wbData infoWord);
        runResult want;
        logic wantLimit;
        for (int i = 0; i < 4; i++) begin
            busCycle(1'b1, regAddr'(i), vals[i], rd);
        end
        want = modelRun(vals, wantLimit);
        busCycle(1'b1, `MAXNET_ADDR_CTRL, 32'd1, rd);
        waitIrq(1'b0, 4);
        // the engine is busy by now, so this start must be dropped
        if (extraStart) begin
            busCycle(1'b1, `MAXNET_ADDR_CTRL, 32'd1, rd);
        end
        waitIrq(1'b1, 4 * `MAXNET_MAX_ITER);
        busCycle(1'b0, `MAXNET_ADDR_STATUS, '0, rd);
        checkEq("STATUS", rd, {28'd0, wantLimit, want.noWinner, 1'b1, 1'b0});
        busCycle(1'b0, `MAXNET_ADDR_MAXVAL, '0, rd);
        checkEq("MAXVAL", rd, want.maxValue);
        busCycle(1'b0, `MAXNET_ADDR_INFO, '0, infoWord);
        checkEq("INFO", infoWord, {16'd0, want.iterations, 6'd0, want.winner});
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (errorCount == mark && !hung) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: failed, %0d mismatches", testCount, name, errorCount - mark);
        end
        mark = errorCount;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        lfsr = 32'h724;
        hung = 1'b0;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        failedTests = 0;
        mark = 0;
        rstN = 1'b0;
        bus = '0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;

        checkEq("irq", 32'(irq), 32'd0);
        busCycle(1'b0, `MAXNET_ADDR_STATUS, '0, rd);
        checkEq("STATUS", rd, 32'd0);
        busCycle(1'b0, `MAXNET_ADDR_MAXVAL, '0, rd);
        checkEq("MAXVAL", rd, 32'd0);
        busCycle(1'b0, `MAXNET_ADDR_INFO, '0, rd);
        checkEq("INFO", rd, 32'd0);
        endTest("after reset");

        for (int i = 0; i < 4; i++) begin
            busCycle(1'b1, regAddr'(i), 32'ha5c3_0f00 ^ (32'h0101_0101 << i), rd);
        end
        for (int i = 0; i < 4; i++) begin
            busCycle(1'b0, regAddr'(i), '0, rd);
            checkEq($sformatf("IN%0d", i), rd, 32'ha5c3_0f00 ^ (32'h0101_0101 << i));
        end
        endTest("register readback");

        // 1.0 3.5 2.0 0.75, then 0.5 1.25 2.0 4.0
        vals = '{32'h0001_0000, 32'h0003_8000, 32'h0002_0000, 32'h0000_c000};
        runCase(1'b0, info);
        checkEq("winner", 32'(info[1:0]), 32'd1);
        vals = '{32'h0000_8000, 32'h0001_4000, 32'h0002_0000, 32'h0004_0000};
        runCase(1'b0, info);
        checkEq("winner", 32'(info[1:0]), 32'd3);
        endTest("distinct positive inputs");

        // the last set keeps lanes 1 and 3 equal until the iteration limit
        vals = '{32'hfffe_8000, 32'h0000_0000, 32'h0002_4000, 32'hffff_8000};
        runCase(1'b0, info);
        vals = '{32'hfffc_0000, 32'hfffc_0000, 32'h0001_0000, 32'h0000_0000};
        runCase(1'b0, info);
        vals = '{32'h0000_0000, 32'h0003_0000, 32'hffff_0000, 32'h0003_0000};
        runCase(1'b0, info);
        endTest("mixed inputs");

        vals = '{default: 32'h0000_0000};
        runCase(1'b0, info);
        vals = '{default: 32'hffff_0000};
        runCase(1'b0, info);
        endTest("ties");

        for (int r = 0; r < 8; r++) begin
            for (int i = 0; i < 4; i++) begin
                rnd = randBits(24);
                vals[i] = {{8{rnd[23]}}, rnd[23:0]};
            end
            runCase(1'b1, info);
        end
        endTest("random runs with ignored start");

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0 && !hung) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
+incdir+sim
src/maxnetPkg.sv
src/inhibitLane.sv
src/maxnetRegDecode.sv
src/maxnetIterate.sv
src/winnerSelect.sv
src/maxnetTop.sv
sim/maxnetTb.sv

/* Makefile */
# Verilator build and run for the MaxNet engine

VERILATOR ?= verilator
TOP ?= maxnetTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= TESTBENCH PASSED

SOURCES := $(wildcard src/*.sv src/*.svh sim/*.sv sim/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
